// File: files.f
+incdir+.
life_board_pkg.sv
life_cmd_pkg.sv
life_cell_rule.sv
life_board.sv
life_stream_buf.sv
life_sequencer.sv
life_engine.sv
tb_life_engine.sv

// File: life_board.sv
// Life board on a torus

`default_nettype none
`timescale 1ns/1ps

`include "life_cfg.svh"

module life_board (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       wr_en,
    input  life_board_pkg::row_beat_t  wr_beat,
    input  logic                       step,
    output life_board_pkg::board_t     rows
);

    life_board_pkg::board_t next_rows;

    // One rule block per cell, neighbours taken modulo the board size
    // so the top row sees the bottom row and column 0 sees the last column
    for (genvar r = 0; r < `LIFE_ROWS; r++) begin : g_row
        localparam int RN = (r + `LIFE_ROWS - 1) % `LIFE_ROWS;
        localparam int RS = (r + 1) % `LIFE_ROWS;

        for (genvar c = 0; c < `LIFE_COLS; c++) begin : g_col
            localparam int CW = (c + `LIFE_COLS - 1) % `LIFE_COLS;
            localparam int CE = (c + 1) % `LIFE_COLS;

            life_cell_rule u_cell (
                .me    (rows[r][c]),
                .n     (rows[RN][c]),
                .ne    (rows[RN][CE]),
                .e     (rows[r][CE]),
                .se    (rows[RS][CE]),
                .s     (rows[RS][c]),
                .sw    (rows[RS][CW]),
                .w     (rows[r][CW]),
                .nw    (rows[RN][CW]),
                .alive (next_rows[r][c])
            );
        end
    end

    // The board starts empty, every cell dead
    always_ff @(posedge clk) begin
        if (reset) begin
            rows <= '0;
        end else if (step) begin
            rows <= next_rows;
        end else if (wr_en) begin
            rows[wr_beat.idx] <= wr_beat.row;
        end
    end

    // The sequencer only loads rows or steps the board, never both at once
    a_no_write_during_step : assert property (
        @(posedge clk) disable iff (reset)
        !(wr_en && step)
    ) else $error("life_board wr_en and step high together");

endmodule

`default_nettype wire

// File: life_board_pkg.sv
// Life board geometry types

`default_nettype none

`include "life_cfg.svh"

package life_board_pkg;

    // One row of cells, bit index equals column
    typedef logic [`LIFE_COLS-1:0] row_t;

    // Row index wide enough to address every row
    typedef logic [$clog2(`LIFE_ROWS)-1:0] row_idx_t;

    // Payload of both row streams
    typedef struct packed {
        row_idx_t idx;
        row_t     row;
    } row_beat_t;

    // The whole board, row 0 at the top
    typedef row_t [`LIFE_ROWS-1:0] board_t;

endpackage

`default_nettype wire

// File: life_cell_rule.sv
// Life cell next-state rule

`default_nettype none
`timescale 1ns/1ps

module life_cell_rule (
    input  logic me,
    input  logic n,
    input  logic ne,
    input  logic e,
    input  logic se,
    input  logic s,
    input  logic sw,
    input  logic w,
    input  logic nw,
    output logic alive
);

    logic [3:0] live_cnt;

    // At most eight live neighbours, so four bits are enough
    assign live_cnt = 4'(n) + 4'(ne) + 4'(e) + 4'(se)
                    + 4'(s) + 4'(sw) + 4'(w) + 4'(nw);

    // Three neighbours gives life whatever the current state,
    // two neighbours only keeps an already live cell alive
    assign alive = (live_cnt == 4'd3) || (me && (live_cnt == 4'd2));

endmodule

`default_nettype wire

// File: life_cfg.svh
// Life engine configuration

`ifndef LIFE_CFG_SVH
`define LIFE_CFG_SVH

// Board width in cells, one bit per column in a row
`define LIFE_COLS 16

// Board height in rows
`define LIFE_ROWS 16

// Width of the generation count carried by a run command
`define LIFE_GEN_W 8

`endif

// File: life_cmd_pkg.sv
// Life command types

`default_nettype none

`include "life_cfg.svh"

package life_cmd_pkg;

    typedef enum logic [1:0] {
        op_load = 2'd0,
        op_run  = 2'd1,
        op_read = 2'd2
    } life_op_t;

    // The generation count only matters for op_run
    typedef struct packed {
        life_op_t                op;
        logic [`LIFE_GEN_W-1:0] gens;
    } life_cmd_t;

endpackage

`default_nettype wire

// File: life_engine.sv
// Life engine top level

`default_nettype none
`timescale 1ns/1ps

module life_engine (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       cmd_valid,
    output logic                       cmd_ready,
    input  life_cmd_pkg::life_cmd_t    cmd,
    input  logic                       in_valid,
    output logic                       in_ready,
    input  life_board_pkg::row_beat_t  in_beat,
    output logic                       out_valid,
    input  logic                       out_ready,
    output life_board_pkg::row_beat_t  out_beat,
    output logic                       busy
);

    logic                      rin_valid;
    logic                      rin_ready;
    life_board_pkg::row_beat_t rin_beat;
    logic                      rout_valid;
    logic                      rout_ready;
    life_board_pkg::row_beat_t rout_beat;
    logic                      wr_en;
    life_board_pkg::row_beat_t wr_beat;
    logic                      step;
    life_board_pkg::board_t    rows;

    life_stream_buf #(
        .payload_t (life_board_pkg::row_beat_t)
    ) u_in_buf (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_beat),
        .out_valid (rin_valid),
        .out_ready (rin_ready),
        .out_data  (rin_beat)
    );

    life_sequencer u_sequencer (
        .clk        (clk),
        .reset      (reset),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .cmd        (cmd),
        .rin_valid  (rin_valid),
        .rin_ready  (rin_ready),
        .rin_beat   (rin_beat),
        .rout_valid (rout_valid),
        .rout_ready (rout_ready),
        .rout_beat  (rout_beat),
        .wr_en      (wr_en),
        .wr_beat    (wr_beat),
        .step       (step),
        .rows       (rows),
        .busy       (busy)
    );

    life_board u_board (
        .clk     (clk),
        .reset   (reset),
        .wr_en   (wr_en),
        .wr_beat (wr_beat),
        .step    (step),
        .rows    (rows)
    );

    life_stream_buf #(
        .payload_t (life_board_pkg::row_beat_t)
    ) u_out_buf (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (rout_valid),
        .in_ready  (rout_ready),
        .in_data   (rout_beat),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_beat)
    );

endmodule

`default_nettype wire

// File: life_sequencer.sv
// Life command sequencer

`default_nettype none
`timescale 1ns/1ps

`include "life_cfg.svh"

module life_sequencer (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       cmd_valid,
    output logic                       cmd_ready,
    input  life_cmd_pkg::life_cmd_t    cmd,
    input  logic                       rin_valid,
    output logic                       rin_ready,
    input  life_board_pkg::row_beat_t  rin_beat,
    output logic                       rout_valid,
    input  logic                       rout_ready,
    output life_board_pkg::row_beat_t  rout_beat,
    output logic                       wr_en,
    output life_board_pkg::row_beat_t  wr_beat,
    output logic                       step,
    input  life_board_pkg::board_t     rows,
    output logic                       busy
);

    typedef enum logic [1:0] {
        s_idle,
        s_load,
        s_run,
        s_read
    } state_t;

    state_t                   state;
    life_board_pkg::row_idx_t row_cnt;
    logic [`LIFE_GEN_W-1:0]   gen_cnt;
    logic                     cmd_fire;
    logic                     rin_fire;
    logic                     rout_fire;
    logic                     last_row;

    assign cmd_ready = (state == s_idle);
    assign busy      = (state != s_idle);
    assign rin_ready = (state == s_load);
    assign rout_valid = (state == s_read);

    assign cmd_fire  = cmd_valid && cmd_ready;
    assign rin_fire  = rin_valid && rin_ready;
    assign rout_fire = rout_valid && rout_ready;
    assign last_row  = (row_cnt == life_board_pkg::row_idx_t'(`LIFE_ROWS - 1));

    // Load beats carry their own index and go straight to the board
    assign wr_en   = rin_fire;
    assign wr_beat = rin_beat;

    // One step per cycle until the count runs out
    assign step = (state == s_run) && (gen_cnt != '0);

    always_comb begin
        rout_beat.idx = row_cnt;
        rout_beat.row = rows[row_cnt];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= s_idle;
            row_cnt <= '0;
            gen_cnt <= '0;
        end else begin
            case (state)
                s_idle: begin
                    if (cmd_fire) begin
                        case (cmd.op)
                            life_cmd_pkg::op_load: state <= s_load;
                            life_cmd_pkg::op_run: begin
                                state   <= s_run;
                                gen_cnt <= cmd.gens;
                            end
                            life_cmd_pkg::op_read: state <= s_read;
                            default: state <= s_idle;
                        endcase
                    end
                end
                s_load: begin
                    // Counts beats, not indices, so any row order works
                    if (rin_fire) begin
                        if (last_row) begin
                            row_cnt <= '0;
                            state   <= s_idle;
                        end else begin
                            row_cnt <= row_cnt + 1'b1;
                        end
                    end
                end
                s_run: begin
                    if (gen_cnt == '0) begin
                        state <= s_idle;
                    end else begin
                        gen_cnt <= gen_cnt - 1'b1;
                    end
                end
                s_read: begin
                    // A stalled output buffer simply holds the counter
                    if (rout_fire) begin
                        if (last_row) begin
                            row_cnt <= '0;
                            state   <= s_idle;
                        end else begin
                            row_cnt <= row_cnt + 1'b1;
                        end
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    // The counter only falls back to row 0 when the last row ends the command,
    // so it never laps past the last row within one load or read
    a_row_cnt_range : assert property (
        @(posedge clk) disable iff (reset)
        (!$stable(row_cnt) && (row_cnt == '0)) |-> (state == s_idle)
    ) else $error("life_sequencer row counter wrapped past the last row");

endmodule

`default_nettype wire

// File: life_stream_buf.sv
// Two-entry valid/ready buffer

`default_nettype none
`timescale 1ns/1ps

module life_stream_buf #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     main_valid;
    payload_t main_data;
    logic     skid_valid;
    payload_t skid_data;
    logic     in_fire;
    logic     main_load;
    logic     skid_fill;
    logic     skid_drain;

    assign in_fire    = in_valid && in_ready;
    // The output register can take a new beat when empty or when it is leaving
    assign main_load  = !main_valid || out_ready;
    assign skid_fill  = in_fire && !main_load;
    assign skid_drain = skid_valid && main_load;

    assign out_valid = main_valid;
    assign out_data  = main_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
            in_ready   <= 1'b0;
        end else begin
            if (main_load) begin
                main_valid <= skid_valid || in_fire;
            end
            if (skid_fill) begin
                skid_valid <= 1'b1;
            end else if (skid_drain) begin
                skid_valid <= 1'b0;
            end
            // Registered ready, low only while the skid entry is occupied
            in_ready <= !(skid_fill || (skid_valid && !skid_drain));
        end
    end

    always_ff @(posedge clk) begin
        if (main_load) begin
            main_data <= skid_valid ? skid_data : in_data;
        end
        if (skid_fill) begin
            skid_data <= in_data;
        end
    end

    a_out_stable : assert property (
        @(posedge clk) disable iff (reset)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data))
    ) else $error("life_stream_buf out_data changed under stall");

endmodule

`default_nettype wire

// File: tb_life_engine.sv
// Life engine testbench

`default_nettype none
`timescale 1ns/1ps

`include "life_cfg.svh"

module tb_life_engine;

    localparam int ROWS = `LIFE_ROWS;
    localparam int COLS = `LIFE_COLS;
    // Four loads and nine reads in total, plus eleven generations
    localparam int LIMIT = 8 * (13 * 2 * ROWS + 11);

    logic                      clk = 1'b0;
    logic                      reset;
    logic                      cmd_valid;
    logic                      cmd_ready;
    life_cmd_pkg::life_cmd_t   cmd;
    logic                      in_valid;
    logic                      in_ready;
    life_board_pkg::row_beat_t in_beat;
    logic                      out_valid;
    logic                      out_ready;
    life_board_pkg::row_beat_t out_beat;
    logic                      busy;

    life_board_pkg::board_t    shadow;
    logic [31:0]               lfsr = 32'h8e05ae0d;
    int                        beats_expected = 0;
    int                        beats_seen = 0;
    int                        cycle_cnt = 0;
    int                        err_cnt = 0;
    int                        err_before = 0;
    int                        tests_run = 0;

    life_engine u_life_engine (
        .clk       (clk),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd       (cmd),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_beat   (in_beat),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_beat  (out_beat),
        .busy      (busy)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt++;
        if (out_valid && out_ready) begin
            beats_seen++;
        end
        if (cycle_cnt > LIMIT) begin
            $display("Run stopped after %0d cycles, the DUT stopped responding", cycle_cnt);
            $display("tests failed");
            $finish;
        end
    end

    a_reset_state : assert property (@(posedge clk) $fell(reset) |->
        (cmd_ready && !in_ready && !out_valid && !busy))
    else begin
        $display("Error after reset cmd_ready %h in_ready %h out_valid %h busy %h",
                 $sampled(cmd_ready), $sampled(in_ready), $sampled(out_valid),
                 $sampled(busy));
        err_cnt++;
    end

    // Every accepted command keeps the engine busy for at least one cycle
    a_busy_after_cmd : assert property (@(posedge clk) disable iff (reset)
        (cmd_valid && cmd_ready) |=> busy)
    else begin
        $display("Error busy got %h expected 1", $sampled(busy));
        err_cnt++;
    end

    a_row_match : assert property (@(posedge clk) disable iff (reset)
        (out_valid && out_ready) |-> (out_beat.row == shadow[out_beat.idx]))
    else begin
        $display("Error out_beat.row at idx %h got %h expected %h", $sampled(out_beat.idx),
                 $sampled(out_beat.row), $sampled(shadow[out_beat.idx]));
        err_cnt++;
    end

    // Beats of all reads are counted together, so the index follows the running count
    a_idx_order : assert property (@(posedge clk) disable iff (reset)
        (out_valid && out_ready) |-> (out_beat.idx == (beats_seen % ROWS)))
    else begin
        $display("Error out_beat.idx got %h expected %h", $sampled(out_beat.idx),
                 $sampled(beats_seen % ROWS));
        err_cnt++;
    end

    a_no_extra_beat : assert property (@(posedge clk) disable iff (reset)
        (out_valid && out_ready) |-> (beats_seen < beats_expected))
    else begin
        $display("Output beat arrived with no read outstanding");
        err_cnt++;
    end

    a_out_stable : assert property (@(posedge clk) disable iff (reset)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_beat)))
    else begin
        $display("Output beat changed or vanished while stalled");
        err_cnt++;
    end

    // Galois LFSR, one step per bit
    function automatic logic rand_bit();
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        return lfsr[0];
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], rand_bit()};
        end
        return v;
    endfunction

    // Reference generation, counting neighbours on the torus
    function automatic life_board_pkg::board_t next_gen(input life_board_pkg::board_t b);
        life_board_pkg::board_t nb;
        int cnt;
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                cnt = 0;
                for (int dr = -1; dr <= 1; dr++) begin
                    for (int dc = -1; dc <= 1; dc++) begin
                        if (dr != 0 || dc != 0) begin
                            cnt += b[(r + dr + ROWS) % ROWS][(c + dc + COLS) % COLS];
                        end
                    end
                end
                nb[r][c] = (cnt == 3) || (b[r][c] && cnt == 2);
            end
        end
        return nb;
    endfunction

    // Glider heading down and right, top left corner of its box at r0, c0
    function automatic life_board_pkg::board_t glider_at(input int r0, input int c0);
        life_board_pkg::board_t b;
        b = '0;
        b[r0 % ROWS][(c0 + 1) % COLS] = 1'b1;
        b[(r0 + 1) % ROWS][(c0 + 2) % COLS] = 1'b1;
        for (int c = 0; c < 3; c++) begin
            b[(r0 + 2) % ROWS][(c0 + c) % COLS] = 1'b1;
        end
        return b;
    endfunction

    task automatic wait_idle();
        @(negedge clk);
        while (!cmd_ready) @(negedge clk);
    endtask

    task automatic send_cmd(input life_cmd_pkg::life_op_t op, input int gens);
        while (!cmd_ready) @(negedge clk);
        cmd_valid = 1'b1;
        cmd.op    = op;
        cmd.gens  = gens[`LIFE_GEN_W-1:0];
        @(negedge clk);
        cmd_valid = 1'b0;
    endtask

    task automatic load_board(input life_board_pkg::board_t b, input logic shuffle);
        int perm [ROWS];
        int j;
        int t;
        for (int i = 0; i < ROWS; i++) begin
            perm[i] = i;
        end
        if (shuffle) begin
            for (int i = ROWS - 1; i > 0; i--) begin
                j = rand_bits(8) % (i + 1);
                t = perm[i];
                perm[i] = perm[j];
                perm[j] = t;
            end
        end
        shadow = b;
        send_cmd(life_cmd_pkg::op_load, 0);
        for (int i = 0; i < ROWS; i++) begin
            if (shuffle) begin
                repeat (rand_bits(2)) @(negedge clk);
            end
            in_valid    = 1'b1;
            in_beat.idx = life_board_pkg::row_idx_t'(perm[i]);
            in_beat.row = b[perm[i]];
            while (!in_ready) @(negedge clk);
            @(negedge clk);
            in_valid = 1'b0;
        end
        wait_idle();
    endtask

    task automatic run_gens(input int gens);
        send_cmd(life_cmd_pkg::op_run, gens);
        repeat (gens) shadow = next_gen(shadow);
        wait_idle();
    endtask

    task automatic read_board(input logic stall);
        beats_expected += ROWS;
        send_cmd(life_cmd_pkg::op_read, 0);
        while (beats_seen != beats_expected || !cmd_ready) begin
            if (stall) begin
                out_ready = rand_bit();
            end
            @(negedge clk);
        end
        out_ready = 1'b1;
    endtask

    task automatic report_test(input string name);
        $display("test %0s: %0s", name, (err_cnt == err_before) ? "pass" : "fail");
        tests_run++;
        err_before = err_cnt;
    endtask

    initial begin
        life_board_pkg::board_t b;
        reset     = 1'b1;
        cmd_valid = 1'b0;
        cmd       = '0;
        in_valid  = 1'b0;
        in_beat   = '0;
        out_ready = 1'b1;
        shadow    = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        read_board(1'b0);
        report_test("reset_state");

        b = '0;
        b[5] = 16'h0070;
        load_board(b, 1'b0);
        run_gens(2);
        read_board(1'b0);
        run_gens(1);
        read_board(1'b0);
        report_test("blinker");

        load_board(glider_at(ROWS - 1, COLS - 1), 1'b0);
        run_gens(4);
        read_board(1'b0);
        assert (shadow == glider_at(0, 0))
        else begin
            $display("Reference glider did not move by one row and one column");
            err_cnt++;
        end
        report_test("glider_wrap");

        for (int r = 0; r < ROWS; r++) begin
            b[r] = life_board_pkg::row_t'(rand_bits(COLS));
        end
        load_board(b, 1'b0);
        run_gens(1);
        read_board(1'b0);
        run_gens(3);
        read_board(1'b0);
        run_gens(0);
        read_board(1'b0);
        report_test("random_board");

        read_board(1'b1);
        report_test("back_pressure");

        for (int r = 0; r < ROWS; r++) begin
            b[r] = life_board_pkg::row_t'(rand_bits(COLS));
        end
        load_board(b, 1'b1);
        read_board(1'b0);
        report_test("load_order");

        $display("%0d tests run, %0d errors", tests_run, err_cnt);
        if (err_cnt == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
